// File: rtl/ising_pkg.sv
// Sizing constants for the Ising energy evaluator
// Spin count, coupling and bias precision, energy widths

package ising_pkg;

    // ====================
    // Base precisions
    // ====================
    localparam int BITJ             = 4;   // Coupling J, signed
    localparam int BITH             = 4;   // Bias h, signed
    localparam int DATASPIN         = 16;  // Spins per problem
    localparam int SCALING_BIT      = 5;   // h scaling code
    localparam int ENERGY_TOTAL_BIT = 16;  // One local energy

    // ====================
    // Derived widths
    // ====================
    // One full coupling row, lane j at [j*BITJ +: BITJ]
    localparam int DATAJ     = DATASPIN * BITJ;
    // Product term, wide enough for h shifted by 16
    localparam int MULTBIT   = BITH + SCALING_BIT - 1;
    localparam int IDX_BIT   = $clog2(DATASPIN);          // Spin index
    // Sum of DATASPIN local energies without overflow
    localparam int TOTAL_BIT = ENERGY_TOTAL_BIT + IDX_BIT;

endpackage

// File: rtl/weight_rd_if.sv
// Read path of the weight memory
// Controller issues index and strobe, memory returns row and bias

interface weight_rd_if
    import ising_pkg::*;
();

    logic                   rd_en;     // Read strobe
    logic [IDX_BIT-1:0]     rd_idx;    // Row to read
    logic [DATAJ-1:0]       rd_row;    // Coupling row, one cycle later
    logic signed [BITH-1:0] rd_hbias;  // Bias of the same entry

    // Sweep controller side
    modport ctrl (
        output rd_en,
        output rd_idx,
        input  rd_row,
        input  rd_hbias
    );

    // Memory side
    modport mem (
        input  rd_en,
        input  rd_idx,
        output rd_row,
        output rd_hbias
    );

endinterface

// File: rtl/adder_tree.sv
// Combinational signed adder tree
// Pairwise levels, one bit of growth per level, result sign-extended

module adder_tree
    import ising_pkg::*;
#(
    parameter int N     = 16,  // Number of terms
    parameter int DATAW = 8    // Width of one term
) (
    input  logic signed [DATAW-1:0]            data_i [N],  // Terms to add
    output logic signed [ENERGY_TOTAL_BIT-1:0] sum_o        // Sum of all terms
);

    // Words left at a level, odd counts round up
    function automatic int words_at(input int lvl);
        return (N + (1 << lvl) - 1) >> lvl;
    endfunction

    // ====================
    // Tree levels
    // ====================
    for (genvar l = 0; l <= $clog2(N); l++) begin : g_lvl
        logic signed [DATAW+l-1:0] word [words_at(l)];  // One extra bit per level

        if (l == 0) begin : g_leaf
            for (genvar w = 0; w < N; w++) begin : g_w
                assign word[w] = data_i[w];
            end
        end else begin : g_node
            for (genvar w = 0; w < words_at(l); w++) begin : g_w
                if (2*w + 1 < words_at(l-1)) begin : g_pair
                    // Signed operands, extended to the wider level
                    assign word[w] = g_lvl[l-1].word[2*w] + g_lvl[l-1].word[2*w+1];
                end else begin : g_odd
                    // Lone word, partner is zero so only the sign extends
                    assign word[w] = g_lvl[l-1].word[2*w];
                end
            end
        end
    end

    // ====================
    // Root
    // ====================
    // Sign-extended to the energy width
    assign sum_o = ENERGY_TOTAL_BIT'(g_lvl[$clog2(N)].word[0]);

endmodule

// File: rtl/partial_energy_calc.sv
// Local energy of one spin, purely combinational
// Coupling sign flip per neighbour, scaled bias on the own lane
// Adder tree sum, flipped by the own spin

module partial_energy_calc
    import ising_pkg::*;
(
    input  logic [DATASPIN-1:0]                spin_i,          // Spin vector, 1 is +1
    input  logic [DATASPIN-1:0]                current_spin_i,  // One-hot, spin k
    input  logic [DATAJ-1:0]                   weight_i,        // Coupling row of spin k
    input  logic signed [BITH-1:0]             hbias_i,         // h of spin k
    input  logic [SCALING_BIT-1:0]             hscaling_i,      // Shift code for h
    output logic signed [ENERGY_TOTAL_BIT-1:0] energy_o         // Local energy
);

    logic signed [MULTBIT-1:0]          weight_ext [DATASPIN];  // Couplings, sign-extended
    logic signed [MULTBIT-1:0]          term       [DATASPIN];  // Tree inputs
    logic signed [MULTBIT-1:0]          hbias_ext;
    logic signed [MULTBIT-1:0]          hbias_scaled;
    logic signed [ENERGY_TOTAL_BIT-1:0] tree_sum;
    logic                               self_spin;              // Own spin bit

    // ====================
    // Coupling lanes
    // ====================
    for (genvar j = 0; j < DATASPIN; j++) begin : g_wext
        assign weight_ext[j] = {{(MULTBIT-BITJ){weight_i[j*BITJ+BITJ-1]}},
                                weight_i[j*BITJ +: BITJ]};
    end

    // ====================
    // Bias scaling
    // ====================
    assign hbias_ext = {{(MULTBIT-BITH){hbias_i[BITH-1]}}, hbias_i};

    // Only powers of two up to 16 are honoured
    always_comb begin
        case (hscaling_i)
            SCALING_BIT'(1):  hbias_scaled = hbias_ext;
            SCALING_BIT'(2):  hbias_scaled = hbias_ext <<< 1;
            SCALING_BIT'(4):  hbias_scaled = hbias_ext <<< 2;
            SCALING_BIT'(8):  hbias_scaled = hbias_ext <<< 3;
            SCALING_BIT'(16): hbias_scaled = hbias_ext <<< 4;
            default:          hbias_scaled = hbias_ext;  // Unknown code acts as 1
        endcase
    end

    // Diagonal lane carries h instead of J_kk
    always_comb begin
        for (int j = 0; j < DATASPIN; j++) begin
            if (current_spin_i[j]) begin
                term[j] = hbias_scaled;
            end else begin
                term[j] = spin_i[j] ? weight_ext[j] : -weight_ext[j];  // J times sigma_j
            end
        end
    end

    // ====================
    // Sum and own spin
    // ====================
    adder_tree #(
        .N     (DATASPIN),
        .DATAW (MULTBIT)
    ) u_adder_tree (
        .data_i (term),
        .sum_o  (tree_sum)
    );

    assign self_spin = |(spin_i & current_spin_i);
    assign energy_o  = self_spin ? tree_sum : -tree_sum;  // Times sigma_k

endmodule

// File: rtl/weight_mem.sv
// Weight register file
// DATASPIN coupling rows and h biases in flip-flops
// Host write port, registered read port with one cycle latency

module weight_mem
    import ising_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   wr_en_i,     // Host write strobe
    input  logic [IDX_BIT-1:0]     wr_idx_i,    // Entry to write
    input  logic [DATAJ-1:0]       wr_row_i,    // Coupling row
    input  logic signed [BITH-1:0] wr_hbias_i,  // h bias
    weight_rd_if.mem               rd           // Read path to the controller
);

    logic [DATAJ-1:0]       row_mem   [DATASPIN];  // Couplings per spin
    logic signed [BITH-1:0] hbias_mem [DATASPIN];  // Bias per spin
    logic [DATAJ-1:0]       rd_row_q;
    logic signed [BITH-1:0] rd_hbias_q;

    // ====================
    // Storage and read
    // ====================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DATASPIN; i++) begin
                row_mem[i]   <= '0;
                hbias_mem[i] <= '0;
            end
            rd_row_q   <= '0;
            rd_hbias_q <= '0;
        end else begin
            if (wr_en_i) begin
                row_mem[wr_idx_i]   <= wr_row_i;
                hbias_mem[wr_idx_i] <= wr_hbias_i;
            end
            // Old contents seen on a same-cycle write
            if (rd.rd_en) begin
                rd_row_q   <= row_mem[rd.rd_idx];
                rd_hbias_q <= hbias_mem[rd.rd_idx];
            end
        end
    end

    // Held until the next read
    assign rd.rd_row   = rd_row_q;
    assign rd.rd_hbias = rd_hbias_q;

endmodule

// File: rtl/energy_sweep_ctrl.sv
// Sweep controller
// Walks the spin index, one row read per cycle
// Registers each local energy, accumulates the total, pulses done

module energy_sweep_ctrl
    import ising_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               start_i,           // Sweep request
    input  logic [DATASPIN-1:0]                spin_i,            // Spin vector to evaluate
    input  logic [SCALING_BIT-1:0]             hscaling_i,        // h scaling code
    input  logic signed [ENERGY_TOTAL_BIT-1:0] energy_i,          // From the calculator
    weight_rd_if.ctrl                          rd,                // Weight read path
    output logic [DATASPIN-1:0]                spin_o,            // Latched spins
    output logic [DATASPIN-1:0]                current_spin_o,    // One-hot spin on rd_row
    output logic [SCALING_BIT-1:0]             hscaling_o,        // Latched code
    output logic                               busy_o,
    output logic                               done_o,
    output logic                               partial_valid_o,
    output logic [IDX_BIT-1:0]                 partial_idx_o,
    output logic signed [ENERGY_TOTAL_BIT-1:0] partial_energy_o,
    output logic signed [TOTAL_BIT-1:0]        total_energy_o
);

    logic                               start_fire;    // Accepted start
    logic                               rd_act_q;      // Reads 1..N-1 pending
    logic [IDX_BIT-1:0]                 rd_cnt_q;      // Next index to read
    logic                               row_vld_q;     // Row on rd outputs
    logic [IDX_BIT-1:0]                 row_idx_q;     // Index of that row
    logic                               busy_q;
    logic                               done_q;
    logic                               pvalid_q;
    logic [IDX_BIT-1:0]                 pidx_q;
    logic signed [ENERGY_TOTAL_BIT-1:0] penergy_q;
    logic signed [TOTAL_BIT-1:0]        penergy_ext;
    logic signed [TOTAL_BIT-1:0]        acc_q;         // Running sum of this sweep
    logic signed [TOTAL_BIT-1:0]        acc_next;
    logic signed [TOTAL_BIT-1:0]        total_q;       // Result of last sweep
    logic                               last_partial;
    logic [DATASPIN-1:0]                spin_q;
    logic [SCALING_BIT-1:0]             hscaling_q;

    assign start_fire = start_i && !busy_q;  // Ignored mid-sweep

    // ====================
    // Read issue
    // ====================
    // Index 0 goes out in the start cycle itself
    assign rd.rd_en  = start_fire || rd_act_q;
    assign rd.rd_idx = rd_act_q ? rd_cnt_q : '0;

    // ====================
    // Accumulate
    // ====================
    assign penergy_ext  = TOTAL_BIT'(penergy_q);  // Sign-extend
    assign acc_next     = acc_q + penergy_ext;
    assign last_partial = pvalid_q && (pidx_q == IDX_BIT'(DATASPIN-1));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_act_q  <= 1'b0;
            rd_cnt_q  <= '0;
            row_vld_q <= 1'b0;
            row_idx_q <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            pvalid_q  <= 1'b0;
            acc_q     <= '0;
            total_q   <= '0;
        end else begin
            if (start_fire) begin
                busy_q   <= 1'b1;
                rd_act_q <= (DATASPIN > 1);
                rd_cnt_q <= IDX_BIT'(1);
            end else if (rd_act_q) begin
                if (rd_cnt_q == IDX_BIT'(DATASPIN-1)) begin
                    rd_act_q <= 1'b0;
                end
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end

            // Index follows the memory latency
            row_vld_q <= rd.rd_en;
            if (rd.rd_en) begin
                row_idx_q <= rd.rd_idx;
            end

            pvalid_q <= row_vld_q;
            done_q   <= last_partial;

            if (start_fire) begin
                acc_q <= '0;
            end else if (pvalid_q) begin
                acc_q <= acc_next;
            end

            // Last partial closes the sweep
            if (last_partial) begin
                busy_q  <= 1'b0;
                total_q <= acc_next;
            end
        end
    end

    // Payload, qualified by the valid flags
    always_ff @(posedge clk_i) begin
        if (start_fire) begin
            spin_q     <= spin_i;
            hscaling_q <= hscaling_i;
        end
        if (row_vld_q) begin
            pidx_q    <= row_idx_q;
            penergy_q <= energy_i;
        end
    end

    // ====================
    // Outputs
    // ====================
    assign spin_o           = spin_q;
    assign hscaling_o       = hscaling_q;
    assign current_spin_o   = DATASPIN'(1) << row_idx_q;
    assign busy_o           = busy_q;
    assign done_o           = done_q;
    assign partial_valid_o  = pvalid_q;
    assign partial_idx_o    = pidx_q;
    assign partial_energy_o = penergy_q;
    assign total_energy_o   = total_q;

endmodule

// File: rtl/ising_energy_top.sv
// Top level of the Ising energy evaluator
// Weight memory, sweep controller and local energy calculator

module ising_energy_top
    import ising_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    // Host weight load
    input  logic                               wr_en_i,
    input  logic [IDX_BIT-1:0]                 wr_idx_i,
    input  logic [DATAJ-1:0]                   wr_row_i,
    input  logic signed [BITH-1:0]             wr_hbias_i,
    // Sweep request
    input  logic [DATASPIN-1:0]                spin_i,
    input  logic [SCALING_BIT-1:0]             hscaling_i,
    input  logic                               start_i,
    // Status and results
    output logic                               busy_o,
    output logic                               done_o,
    output logic                               partial_valid_o,
    output logic [IDX_BIT-1:0]                 partial_idx_o,
    output logic signed [ENERGY_TOTAL_BIT-1:0] partial_energy_o,
    output logic signed [TOTAL_BIT-1:0]        total_energy_o
);

    logic [DATASPIN-1:0]                spin_lat;      // Latched spins
    logic [DATASPIN-1:0]                current_spin;  // One-hot mask
    logic [SCALING_BIT-1:0]             hscaling_lat;
    logic signed [ENERGY_TOTAL_BIT-1:0] local_energy;  // Calculator result

    weight_rd_if u_rd_if ();

    // ====================
    // Weight storage
    // ====================
    weight_mem u_weight_mem (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wr_en_i    (wr_en_i),
        .wr_idx_i   (wr_idx_i),
        .wr_row_i   (wr_row_i),
        .wr_hbias_i (wr_hbias_i),
        .rd         (u_rd_if.mem)
    );

    // ====================
    // Sweep
    // ====================
    energy_sweep_ctrl u_ctrl (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .start_i          (start_i),
        .spin_i           (spin_i),
        .hscaling_i       (hscaling_i),
        .energy_i         (local_energy),
        .rd               (u_rd_if.ctrl),
        .spin_o           (spin_lat),
        .current_spin_o   (current_spin),
        .hscaling_o       (hscaling_lat),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .partial_valid_o  (partial_valid_o),
        .partial_idx_o    (partial_idx_o),
        .partial_energy_o (partial_energy_o),
        .total_energy_o   (total_energy_o)
    );

    // Row and bias straight off the read registers
    partial_energy_calc u_calc (
        .spin_i         (spin_lat),
        .current_spin_i (current_spin),
        .weight_i       (u_rd_if.rd_row),
        .hbias_i        (u_rd_if.rd_hbias),
        .hscaling_i     (hscaling_lat),
        .energy_o       (local_energy)
    );

endmodule

// File: include/ising_tb_checks.svh
// Testbench compare tasks and error counters
// Reference model of the local energy of one spin

`ifndef ISING_TB_CHECKS_SVH
`define ISING_TB_CHECKS_SVH

int value_errors    = 0;  // Wrong values
int protocol_errors = 0;  // Missing, extra or late pulses

task automatic check_energy(input string name,
                            input logic signed [ENERGY_TOTAL_BIT-1:0] exp,
                            input logic signed [ENERGY_TOTAL_BIT-1:0] act);
    if (act !== exp) begin
        value_errors++;
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic verify_index(input string name, input logic [IDX_BIT-1:0] exp,
                            input logic [IDX_BIT-1:0] act);
    if (act !== exp) begin
        value_errors++;
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic compare_total(input string name, input logic signed [TOTAL_BIT-1:0] exp,
                             input logic signed [TOTAL_BIT-1:0] act);
    if (act !== exp) begin
        value_errors++;
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic expect_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        value_errors++;
        $display("Fail %s: expected %0b, actual %0b", name, exp, act);
    end
endtask

task automatic note_protocol_error(input string msg);
    protocol_errors++;
    $display("Error: %s", msg);
endtask

// sigma_k * (sum over j != k of J_kj * sigma_j + h_k * scale)
function automatic logic signed [ENERGY_TOTAL_BIT-1:0] ref_local_energy(
    input logic [DATAJ-1:0] row, input logic signed [BITH-1:0] h,
    input logic [DATASPIN-1:0] spins, input logic [SCALING_BIT-1:0] code, input int k);
    int acc;
    int jv;
    int factor;
    acc = 0;
    for (int j = 0; j < DATASPIN; j++) begin
        jv = int'($signed(row[j*BITJ +: BITJ]));
        if (j != k) acc += spins[j] ? jv : -jv;  // Diagonal skipped
    end
    factor = int'(code);
    if (factor != 2 && factor != 4 && factor != 8 && factor != 16) factor = 1;
    acc += int'(h) * factor;
    if (!spins[k]) acc = -acc;  // Spin bit 0 is -1
    return ENERGY_TOTAL_BIT'(acc);
endfunction

`endif

// File: verif/tb_ising_energy.sv
// Testbench of the Ising energy evaluator
// Clock, reset, weight loading, stimulus table loop, row rewrite test, watchdog

module tb_ising_energy
    import ising_pkg::*;
();

    `include "ising_tb_checks.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_STIM     = 10;
    localparam int NUM_SWEEPS   = NUM_STIM + 4;     // Plus cleared and rewrite sweeps
    localparam int SWEEP_CYCLES = DATASPIN + 10;
    localparam int LOAD_CYCLES  = RESET_CYCLES + 2 * DATASPIN + 20;
    localparam int WATCHDOG_CYCLES = NUM_SWEEPS * SWEEP_CYCLES + LOAD_CYCLES;
    localparam int POKE_CYCLE   = 5;                // Stray start mid-sweep
    localparam int REWRITE_IDX  = 6;

    typedef struct packed {
        logic [DATASPIN-1:0]    spins;
        logic [SCALING_BIT-1:0] code;
        logic                   poke;  // Extra start during the sweep
    } stim_t;

    logic                               clk;
    logic                               arst_n;
    logic                               wr_en;
    logic [IDX_BIT-1:0]                 wr_idx;
    logic [DATAJ-1:0]                   wr_row;
    logic signed [BITH-1:0]             wr_hbias;
    logic [DATASPIN-1:0]                spin;
    logic [SCALING_BIT-1:0]             hscaling;
    logic                               start;
    logic                               busy;
    logic                               done;
    logic                               pvalid;
    logic [IDX_BIT-1:0]                 pidx;
    logic signed [ENERGY_TOTAL_BIT-1:0] penergy;
    logic signed [TOTAL_BIT-1:0]        total;
    logic signed [TOTAL_BIT-1:0]        model_total;  // Expected result of the last sweep

    stim_t                              stim_tab    [NUM_STIM];
    logic [DATAJ-1:0]                   w_row       [DATASPIN];  // Own copy of the weights
    logic signed [BITH-1:0]             w_h         [DATASPIN];
    logic signed [ENERGY_TOTAL_BIT-1:0] last_parts  [DATASPIN];  // Stream of last sweep
    logic signed [ENERGY_TOTAL_BIT-1:0] saved_parts [DATASPIN];

    ising_energy_top dut (
        .clk_i (clk), .arst_n_i (arst_n),
        .wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_row_i (wr_row), .wr_hbias_i (wr_hbias),
        .spin_i (spin), .hscaling_i (hscaling), .start_i (start),
        .busy_o (busy), .done_o (done), .partial_valid_o (pvalid),
        .partial_idx_o (pidx), .partial_energy_o (penergy), .total_energy_o (total)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Called at 1 unit after a rising edge, returns the same way
    task automatic write_weight(input int idx, input logic [DATAJ-1:0] row,
                                input logic signed [BITH-1:0] h);
        wr_en    = 1'b1;
        wr_idx   = IDX_BIT'(idx);
        wr_row   = row;
        wr_hbias = h;
        @(posedge clk);
        #1;
        wr_en    = 1'b0;
        w_row[idx] = row;
        w_h[idx]   = h;
    endtask

    // ====================
    // One sweep, checked cycle by cycle at the falling edge
    // ====================
    task automatic run_sweep(input string name, input logic [DATASPIN-1:0] spins,
                             input logic [SCALING_BIT-1:0] code, input logic poke);
        logic signed [ENERGY_TOTAL_BIT-1:0] exp_part [DATASPIN];
        int  exp_sum;
        int  got_sum;
        int  n_part;
        int  cyc;
        bit  done_seen;
        exp_sum   = 0;
        got_sum   = 0;
        n_part    = 0;
        cyc       = 0;
        done_seen = 1'b0;
        for (int k = 0; k < DATASPIN; k++) begin
            exp_part[k] = ref_local_energy(w_row[k], w_h[k], spins, code, k);
            exp_sum += int'(exp_part[k]);
        end
        spin     = spins;
        hscaling = code;
        start    = 1'b1;
        @(posedge clk);                      // Start sampled, cycle 0
        #1;
        start    = 1'b0;
        spin     = ~spins;                   // DUT must use its latched copy
        hscaling = SCALING_BIT'(code + 3);
        while (!done_seen && cyc < SWEEP_CYCLES) begin
            @(negedge clk);
            cyc++;                           // Value seen at rising edge cyc
            expect_flag($sformatf("%s busy cycle %0d", name, cyc), cyc <= DATASPIN + 1, busy);
            if (pvalid) begin
                if (n_part >= DATASPIN) begin
                    note_protocol_error($sformatf("%s: extra partial pulse at cycle %0d",
                                                  name, cyc));
                end else begin
                    if (cyc != n_part + 2)
                        note_protocol_error($sformatf("%s: partial %0d came at cycle %0d",
                                                      name, n_part, cyc));
                    verify_index($sformatf("%s index %0d", name, n_part), IDX_BIT'(n_part), pidx);
                    check_energy($sformatf("%s energy %0d", name, n_part), exp_part[n_part],
                                 penergy);
                    last_parts[n_part] = penergy;
                    got_sum += int'(penergy);
                end
                n_part++;
            end
            if (done) begin
                done_seen = 1'b1;
                if (cyc != DATASPIN + 2)
                    note_protocol_error($sformatf("%s: done came at cycle %0d", name, cyc));
                compare_total({name, " total"}, TOTAL_BIT'(exp_sum), total);
                compare_total({name, " sum of partials"}, TOTAL_BIT'(got_sum), total);
            end else begin
                compare_total({name, " held total"}, model_total, total);  // Old result stays
            end
            if (!done_seen) begin
                @(posedge clk);
                #1;
                start = poke && (cyc == POKE_CYCLE);
                if (start) begin
                    spin     = DATASPIN'($urandom());
                    hscaling = SCALING_BIT'($urandom());
                end
            end
        end
        if (!done_seen) note_protocol_error($sformatf("%s: done never pulsed", name));
        if (n_part != DATASPIN)
            note_protocol_error($sformatf("%s: %0d partial pulses instead of %0d",
                                          name, n_part, DATASPIN));
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        expect_flag({name, " done after pulse"}, 1'b0, done);   // Single cycle pulse
        expect_flag({name, " valid after done"}, 1'b0, pvalid);
        compare_total({name, " total after done"}, TOTAL_BIT'(exp_sum), total);
        model_total = TOTAL_BIT'(exp_sum);
        @(posedge clk);
        #1;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        logic [DATAJ-1:0] new_row;
        void'($urandom(31907));
        clk         = 1'b0;
        arst_n      = 1'b0;
        wr_en       = 1'b0;
        wr_idx      = '0;
        wr_row      = '0;
        wr_hbias    = '0;
        spin        = '0;
        hscaling    = '0;
        start       = 1'b0;
        model_total = '0;  // Cleared by reset
        for (int i = 0; i < DATASPIN; i++) begin
            w_row[i] = '0;  // Matches the cleared memory
            w_h[i]   = '0;
        end
        stim_tab[0] = '{16'h0000, 5'd1,  1'b0};   // All spins -1
        stim_tab[1] = '{16'hFFFF, 5'd1,  1'b0};   // All spins +1
        stim_tab[2] = '{16'hA5C3, 5'd2,  1'b0};
        stim_tab[3] = '{16'h3C96, 5'd4,  1'b1};
        stim_tab[4] = '{16'h0F0F, 5'd8,  1'b0};
        stim_tab[5] = '{16'h1234, 5'd16, 1'b0};
        stim_tab[6] = '{16'h5A5A, 5'd0,  1'b0};   // Unknown codes act as 1
        stim_tab[7] = '{16'h5A5A, 5'd3,  1'b1};
        stim_tab[8] = '{16'h5A5A, 5'd31, 1'b0};
        stim_tab[9] = '{16'hE71B, 5'd1,  1'b1};

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        expect_flag("reset busy", 1'b0, busy);
        expect_flag("reset done", 1'b0, done);
        expect_flag("reset valid", 1'b0, pvalid);
        compare_total("reset total", '0, total);
        @(posedge clk);
        #1;
        run_sweep("cleared", 16'hFFFF, 5'd16, 1'b0);  // Zero weights, zero partials

        for (int i = 0; i < DATASPIN; i++) begin
            write_weight(i, {$urandom(), $urandom()}, BITH'($urandom()));
        end
        for (int i = 0; i < NUM_STIM; i++) begin
            run_sweep($sformatf("entry%0d", i), stim_tab[i].spins, stim_tab[i].code,
                      stim_tab[i].poke);
        end

        // Rewrite one row, only that spin may change
        run_sweep("pre_rewrite", 16'hC3A5, 5'd4, 1'b0);
        for (int k = 0; k < DATASPIN; k++) begin
            saved_parts[k] = ref_local_energy(w_row[k], w_h[k], 16'hC3A5, 5'd4, k);
        end
        new_row = {$urandom(), $urandom()};
        write_weight(REWRITE_IDX, new_row, BITH'($urandom()));
        run_sweep("rewrite", 16'hC3A5, 5'd4, 1'b0);
        for (int k = 0; k < DATASPIN; k++) begin
            if (k != REWRITE_IDX)
                check_energy($sformatf("rewrite keeps %0d", k), saved_parts[k], last_parts[k]);
        end
        for (int k = 0; k < DATASPIN; k++) begin
            saved_parts[k] = ref_local_energy(w_row[k], w_h[k], 16'hC3A5, 5'd4, k);
        end
        // Diagonal lane only, no energy moves
        new_row[REWRITE_IDX*BITJ +: BITJ] = ~new_row[REWRITE_IDX*BITJ +: BITJ];
        write_weight(REWRITE_IDX, new_row, w_h[REWRITE_IDX]);
        run_sweep("diag_rewrite", 16'hC3A5, 5'd4, 1'b0);
        for (int k = 0; k < DATASPIN; k++) begin
            check_energy($sformatf("diagonal keeps %0d", k), saved_parts[k], last_parts[k]);
        end

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Ends a stuck run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: ising_energy.f
+incdir+include
rtl/ising_pkg.sv
rtl/weight_rd_if.sv
rtl/adder_tree.sv
rtl/partial_energy_calc.sv
rtl/weight_mem.sv
rtl/energy_sweep_ctrl.sv
rtl/ising_energy_top.sv
verif/tb_ising_energy.sv

// File: run.sh
#!/bin/sh
# Build and run the Ising energy testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_ising_energy \
    -f ising_energy.f \
    -o sim_ising_energy

out=$(./obj_dir/sim_ising_energy)
echo "$out"
echo "$out" | grep -qx "TEST PASS"
